//--- checker_params.svh
`ifndef CHECKER_PARAMS_SVH
`define CHECKER_PARAMS_SVH

// Datapath widths
`define CHECKER_DATA_W      64
`define CHECKER_INSTR_W     48
`define CHECKER_PROG_AW     8

// Host page read
`define CHECKER_PAGE_WORDS  8
`define CHECKER_HM_TIMEOUT  32

// CSR page, selected by csr_a_i[13:10]
`define CHECKER_CSR_PAGE    4'h0

// Register offsets in csr_a_i[2:0]
`define CHECKER_REG_CTRL    3'd0
`define CHECKER_REG_ADDR_LO 3'd1
`define CHECKER_REG_ADDR_HI 3'd2
`define CHECKER_REG_STATUS  3'd3
`define CHECKER_REG_DATA_LO 3'd4
`define CHECKER_REG_DATA_HI 3'd5

`endif

//--- checker_pkg.sv
`include "checker_params.svh"

package checker_pkg;

  // Auto mode is kept as an encoding only and runs as dummy
  typedef enum logic [1:0] {
    MODE_DUMMY  = 2'd0,
    MODE_SINGLE = 2'd1,
    MODE_AUTO   = 2'd2,
    MODE_READ   = 2'd3
  } mode_e;

  typedef enum logic [7:0] {
    OP_NOP  = 8'd0,
    OP_ADD  = 8'd1,
    OP_XOR  = 8'd2,
    OP_IRQ  = 8'd3,
    OP_END  = 8'd4,
    OP_FAIL = 8'd5
  } op_e;

  typedef struct packed {
    op_e                                op;
    logic [`CHECKER_INSTR_W-9:0]        operand;
  } instr_t;

  typedef struct packed {
    mode_e                              mode;
    logic                               start;
    logic                               irq_clr;
    logic [`CHECKER_DATA_W-1:0]         addr;
  } mode_cmd_t;

  typedef struct packed {
    logic                               done;
    logic                               irq;
    logic                               error;
    logic [`CHECKER_DATA_W-1:0]         data;
  } mode_res_t;

  typedef struct packed {
    logic                               valid;
    logic [`CHECKER_DATA_W-1:0]         addr;
  } hm_req_t;

  typedef struct packed {
    logic                               valid;
    logic [`CHECKER_DATA_W-1:0]         data;
  } hm_rsp_t;

  typedef struct packed {
    logic                               cyc;
    logic                               stb;
    logic                               we;
    logic [31:0]                        adr;
    logic [31:0]                        dat;
  } wb_req_t;

endpackage

//--- checker_ctlif.sv
`include "checker_params.svh"

module checker_ctlif (
  input  logic                   mpu_clk,
  input  logic                   mpu_rst,
  input  logic [13:0]            csr_a_i,
  input  logic                   csr_we_i,
  input  logic [31:0]            csr_di_i,
  output logic [31:0]            csr_do_o,
  input  checker_pkg::mode_res_t res_i,
  output checker_pkg::mode_cmd_t cmd_o,
  output logic                   busy_o
);

  logic               csr_sel;
  logic [2:0]         reg_off;
  logic               cfg_we;
  logic               start_req;
  checker_pkg::mode_e mode_q;
  logic [31:0]        addr_lo_q;
  logic [31:0]        addr_hi_q;
  logic               start_q;
  logic               irq_clr_q;
  logic               busy_q;
  logic [31:0]        rd_data;

  assign csr_sel   = csr_a_i[13:10] == `CHECKER_CSR_PAGE;
  assign reg_off   = csr_a_i[2:0];
  // Mode and address are frozen during a run
  assign cfg_we    = csr_sel && csr_we_i && !busy_q;
  assign start_req = cfg_we && reg_off == `CHECKER_REG_CTRL && csr_di_i[0];

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst) begin
      mode_q    <= checker_pkg::MODE_DUMMY;
      addr_lo_q <= '0;
      addr_hi_q <= '0;
    end else if (cfg_we) begin
      case (reg_off)
        `CHECKER_REG_CTRL:    mode_q <= checker_pkg::mode_e'(csr_di_i[2:1]);
        `CHECKER_REG_ADDR_LO: addr_lo_q <= csr_di_i;
        `CHECKER_REG_ADDR_HI: addr_hi_q <= csr_di_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst) begin
      start_q   <= 1'b0;
      irq_clr_q <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      start_q   <= start_req;
      irq_clr_q <= csr_sel && csr_we_i && reg_off == `CHECKER_REG_STATUS;
      if (start_req) begin
        busy_q <= 1'b1;
      end else if (res_i.done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (reg_off)
      `CHECKER_REG_CTRL:    rd_data = {29'd0, mode_q, 1'b0};
      `CHECKER_REG_ADDR_LO: rd_data = addr_lo_q;
      `CHECKER_REG_ADDR_HI: rd_data = addr_hi_q;
      `CHECKER_REG_STATUS:  rd_data = {29'd0, res_i.irq, res_i.error, busy_q};
      `CHECKER_REG_DATA_LO: rd_data = res_i.data[31:0];
      `CHECKER_REG_DATA_HI: rd_data = res_i.data[63:32];
      default:              rd_data = '0;
    endcase
  end

  // Registered readback, one cycle after the address
  always_ff @(posedge mpu_clk) begin
    if (mpu_rst) begin
      csr_do_o <= '0;
    end else begin
      csr_do_o <= csr_sel ? rd_data : '0;
    end
  end

  always_comb begin
    cmd_o.mode    = mode_q;
    cmd_o.start   = start_q;
    cmd_o.irq_clr = irq_clr_q;
    cmd_o.addr    = {addr_hi_q, addr_lo_q};
  end

  assign busy_o = busy_q;

endmodule

//--- checker_prog_mem.sv
`include "checker_params.svh"

module checker_prog_mem (
  input  logic                        mpu_clk,
  input  logic                        mpu_rst,
  input  checker_pkg::wb_req_t        wb_i,
  output logic [31:0]                 wb_dat_o,
  output logic                        wb_ack_o,
  input  logic                        busy_i,
  input  logic [`CHECKER_PROG_AW-1:0] rd_addr_i,
  output checker_pkg::instr_t         rd_data_o
);

  logic [`CHECKER_INSTR_W-1:0] mem [2**`CHECKER_PROG_AW];
  logic [`CHECKER_PROG_AW-1:0] wb_idx;
  logic                        wb_hi;
  logic                        wb_cycle;
  logic [`CHECKER_INSTR_W-1:0] wb_word;

  // Byte address, adr[2] picks the half of a 48-bit word
  assign wb_idx   = wb_i.adr[`CHECKER_PROG_AW+2:3];
  assign wb_hi    = wb_i.adr[2];
  assign wb_cycle = wb_i.cyc && wb_i.stb && !wb_ack_o;
  assign wb_word  = mem[wb_idx];

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_cycle;
    end
  end

  always_ff @(posedge mpu_clk) begin
    // Writes during a run are acked but not stored
    if (wb_cycle && wb_i.we && !busy_i) begin
      if (wb_hi) begin
        mem[wb_idx][`CHECKER_INSTR_W-1:32] <= wb_i.dat[`CHECKER_INSTR_W-33:0];
      end else begin
        mem[wb_idx][31:0] <= wb_i.dat;
      end
    end
    if (wb_cycle) begin
      wb_dat_o <= wb_hi ? {{(64 - `CHECKER_INSTR_W){1'b0}}, wb_word[`CHECKER_INSTR_W-1:32]}
                        : wb_word[31:0];
    end
  end

  // Checker fetch port
  always_ff @(posedge mpu_clk) begin
    rd_data_o <= checker_pkg::instr_t'(mem[rd_addr_i]);
  end

endmodule

//--- checker_single.sv
`include "checker_params.svh"

module checker_single (
  input  logic                        mpu_clk,
  input  logic                        mpu_rst,
  input  checker_pkg::mode_cmd_t      cmd_i,
  output logic [`CHECKER_PROG_AW-1:0] rd_addr_o,
  input  checker_pkg::instr_t         rd_data_i,
  output checker_pkg::mode_res_t      res_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC
  } state_e;

  state_e                      state_q;
  logic [`CHECKER_PROG_AW-1:0] pc_q;
  logic [`CHECKER_DATA_W-1:0]  acc_q;
  logic [`CHECKER_DATA_W-1:0]  operand;
  logic                        start;
  logic                        op_end;
  logic                        op_fail;
  logic                        stop;
  logic                        done_q;
  logic                        irq_q;
  logic                        err_q;

  assign start   = cmd_i.start && cmd_i.mode == checker_pkg::MODE_SINGLE;
  assign operand = `CHECKER_DATA_W'(rd_data_i.operand);
  assign op_end  = rd_data_i.op == checker_pkg::OP_END;
  assign op_fail = rd_data_i.op == checker_pkg::OP_FAIL;
  // Running off the last word is an error
  assign stop    = op_end || op_fail || pc_q == '1;

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst) begin
      state_q <= S_IDLE;
      pc_q    <= '0;
      done_q  <= 1'b0;
      irq_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      irq_q  <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start) begin
            pc_q    <= cmd_i.addr[`CHECKER_PROG_AW-1:0];
            state_q <= S_FETCH;
          end
        end
        // Memory read takes this cycle
        S_FETCH: state_q <= S_EXEC;
        S_EXEC: begin
          irq_q <= rd_data_i.op == checker_pkg::OP_IRQ;
          if (stop) begin
            done_q  <= 1'b1;
            err_q   <= !op_end;
            state_q <= S_IDLE;
          end else begin
            pc_q    <= pc_q + 1'b1;
            state_q <= S_FETCH;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge mpu_clk) begin
    if (start) begin
      acc_q <= '0;
    end else if (state_q == S_EXEC) begin
      case (rd_data_i.op)
        checker_pkg::OP_ADD: acc_q <= acc_q + operand;
        checker_pkg::OP_XOR: acc_q <= acc_q ^ operand;
        default: ;
      endcase
    end
  end

  assign rd_addr_o = pc_q;

  always_comb begin
    res_o.done  = done_q;
    res_o.irq   = irq_q;
    res_o.error = err_q;
    res_o.data  = acc_q;
  end

endmodule

//--- checker_read.sv
`include "checker_params.svh"

module checker_read (
  input  logic                   mpu_clk,
  input  logic                   mpu_rst,
  input  checker_pkg::mode_cmd_t cmd_i,
  output checker_pkg::hm_req_t   hm_req_o,
  input  checker_pkg::hm_rsp_t   hm_rsp_i,
  output checker_pkg::mode_res_t res_o
);

  localparam int IDX_W = $clog2(`CHECKER_PAGE_WORDS);
  localparam int TMR_W = $clog2(`CHECKER_HM_TIMEOUT + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT
  } state_e;

  state_e                     state_q;
  logic [IDX_W-1:0]           idx_q;
  logic [TMR_W-1:0]           timer_q;
  logic [`CHECKER_DATA_W-1:0] base_q;
  logic [`CHECKER_DATA_W-1:0] sum_q;
  logic [`CHECKER_DATA_W-1:0] req_addr_q;
  logic                       req_v_q;
  logic                       done_q;
  logic                       err_q;
  logic                       start;

  assign start = cmd_i.start && cmd_i.mode == checker_pkg::MODE_READ;

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst) begin
      state_q <= S_IDLE;
      idx_q   <= '0;
      timer_q <= '0;
      req_v_q <= 1'b0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      req_v_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start) begin
            idx_q   <= '0;
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          req_v_q <= 1'b1;
          timer_q <= '0;
          state_q <= S_WAIT;
        end
        S_WAIT: begin
          if (hm_rsp_i.valid) begin
            if (idx_q == IDX_W'(`CHECKER_PAGE_WORDS - 1)) begin
              done_q  <= 1'b1;
              err_q   <= 1'b0;
              state_q <= S_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= S_REQ;
            end
          end else if (timer_q == TMR_W'(`CHECKER_HM_TIMEOUT)) begin
            // Host gave no answer, report the partial sum
            done_q  <= 1'b1;
            err_q   <= 1'b1;
            state_q <= S_IDLE;
          end else begin
            timer_q <= timer_q + 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge mpu_clk) begin
    if (start) begin
      base_q <= cmd_i.addr;
      sum_q  <= '0;
    end else if (state_q == S_WAIT && hm_rsp_i.valid) begin
      sum_q <= sum_q + hm_rsp_i.data;
    end
    // 8-byte host words
    if (state_q == S_REQ) begin
      req_addr_q <= base_q + (`CHECKER_DATA_W'(idx_q) << 3);
    end
  end

  always_comb begin
    hm_req_o.valid = req_v_q;
    hm_req_o.addr  = req_addr_q;
    res_o.done     = done_q;
    res_o.irq      = 1'b0;
    res_o.error    = err_q;
    res_o.data     = sum_q;
  end

endmodule

//--- checker_result.sv
`include "checker_params.svh"

module checker_result (
  input  logic                   mpu_clk,
  input  logic                   mpu_rst,
  input  checker_pkg::mode_cmd_t cmd_i,
  input  checker_pkg::mode_res_t single_i,
  input  checker_pkg::mode_res_t read_i,
  output checker_pkg::mode_res_t res_o,
  output logic                   irq_o
);

  logic                       dummy_mode;
  logic                       dummy_done_q;
  logic                       done;
  logic                       err;
  logic [`CHECKER_DATA_W-1:0] data;
  logic [`CHECKER_DATA_W-1:0] data_q;
  logic                       err_q;
  logic                       irq_q;

  // Auto runs as dummy
  assign dummy_mode = cmd_i.mode == checker_pkg::MODE_DUMMY ||
                      cmd_i.mode == checker_pkg::MODE_AUTO;

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst) begin
      dummy_done_q <= 1'b0;
    end else begin
      dummy_done_q <= cmd_i.start && dummy_mode;
    end
  end

  assign done = dummy_done_q || single_i.done || read_i.done;
  assign err  = (single_i.done && single_i.error) || (read_i.done && read_i.error);

  // Dummy ends with zero data
  always_comb begin
    if (single_i.done) begin
      data = single_i.data;
    end else if (read_i.done) begin
      data = read_i.data;
    end else begin
      data = '0;
    end
  end

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst || cmd_i.start) begin
      data_q <= '0;
      err_q  <= 1'b0;
    end else if (done) begin
      data_q <= data;
      err_q  <= err;
    end
  end

  always_ff @(posedge mpu_clk) begin
    if (mpu_rst || cmd_i.start || cmd_i.irq_clr) begin
      irq_q <= 1'b0;
    end else if (done || single_i.irq || read_i.irq) begin
      irq_q <= 1'b1;
    end
  end

  assign irq_o = irq_q;

  // Merged end pulse with the held result and irq level
  always_comb begin
    res_o.done  = done;
    res_o.irq   = irq_q;
    res_o.error = err_q;
    res_o.data  = data_q;
  end

endmodule

//--- checker_top.sv
`include "checker_params.svh"

module checker_top (
  input  logic                 mpu_clk,
  input  logic                 mpu_rst,
  input  logic [13:0]          csr_a_i,
  input  logic                 csr_we_i,
  input  logic [31:0]          csr_di_i,
  output logic [31:0]          csr_do_o,
  output logic                 irq_o,
  input  checker_pkg::wb_req_t wb_i,
  output logic [31:0]          wb_dat_o,
  output logic                 wb_ack_o,
  output checker_pkg::hm_req_t hm_req_o,
  input  checker_pkg::hm_rsp_t hm_rsp_i
);

  checker_pkg::mode_cmd_t      cmd;
  checker_pkg::mode_res_t      res;
  checker_pkg::mode_res_t      single_res;
  checker_pkg::mode_res_t      read_res;
  checker_pkg::instr_t         prog_data;
  logic [`CHECKER_PROG_AW-1:0] prog_addr;
  logic                        busy;

  checker_ctlif ctlif_i (
    .mpu_clk  (mpu_clk),
    .mpu_rst  (mpu_rst),
    .csr_a_i  (csr_a_i),
    .csr_we_i (csr_we_i),
    .csr_di_i (csr_di_i),
    .csr_do_o (csr_do_o),
    .res_i    (res),
    .cmd_o    (cmd),
    .busy_o   (busy)
  );

  // Program memory is write protected while busy
  checker_prog_mem prog_mem_i (
    .mpu_clk   (mpu_clk),
    .mpu_rst   (mpu_rst),
    .wb_i      (wb_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .busy_i    (busy),
    .rd_addr_i (prog_addr),
    .rd_data_o (prog_data)
  );

  checker_single single_i (
    .mpu_clk   (mpu_clk),
    .mpu_rst   (mpu_rst),
    .cmd_i     (cmd),
    .rd_addr_o (prog_addr),
    .rd_data_i (prog_data),
    .res_o     (single_res)
  );

  checker_read read_i (
    .mpu_clk  (mpu_clk),
    .mpu_rst  (mpu_rst),
    .cmd_i    (cmd),
    .hm_req_o (hm_req_o),
    .hm_rsp_i (hm_rsp_i),
    .res_o    (read_res)
  );

  checker_result result_i (
    .mpu_clk  (mpu_clk),
    .mpu_rst  (mpu_rst),
    .cmd_i    (cmd),
    .single_i (single_res),
    .read_i   (read_res),
    .res_o    (res),
    .irq_o    (irq_o)
  );

endmodule

//--- tb_checker.sv
`include "checker_params.svh"

module tb_checker;

  // Wide margin over the length of all tests
  localparam int CYCLE_LIMIT = 20000;
  localparam int RUN_LIMIT   = 500;

  logic                   mpu_clk;
  logic                   mpu_rst;
  logic [13:0]            csr_a_i;
  logic                   csr_we_i;
  logic [31:0]            csr_di_i;
  logic [31:0]            csr_do_o;
  logic                   irq_o;
  checker_pkg::wb_req_t   wb_i;
  logic [31:0]            wb_dat_o;
  logic                   wb_ack_o;
  checker_pkg::hm_req_t   hm_req_o;
  checker_pkg::hm_rsp_t   hm_rsp_i;

  int          err_value;
  int          err_proto;
  int          err_other;
  int          cycles;
  logic [63:0] rng_state;
  logic [63:0] hm_base;
  int          hm_idx;
  int          hm_hold;

  checker_top dut_i (
    .mpu_clk  (mpu_clk),
    .mpu_rst  (mpu_rst),
    .csr_a_i  (csr_a_i),
    .csr_we_i (csr_we_i),
    .csr_di_i (csr_di_i),
    .csr_do_o (csr_do_o),
    .irq_o    (irq_o),
    .wb_i     (wb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .hm_req_o (hm_req_o),
    .hm_rsp_i (hm_rsp_i)
  );

  initial begin
    mpu_clk = 1'b0;
    forever #50 mpu_clk = ~mpu_clk;
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  function automatic logic [63:0] next_rand();
    rng_state = xorshift64(rng_state);
    return rng_state;
  endfunction

  function automatic logic [13:0] csr_addr(input logic [2:0] off);
    return {`CHECKER_CSR_PAGE, 7'd0, off};
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      err_value++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic csr_write(input logic [2:0] off, input logic [31:0] data);
    @(posedge mpu_clk);
    csr_a_i  <= csr_addr(off);
    csr_we_i <= 1'b1;
    csr_di_i <= data;
    @(posedge mpu_clk);
    csr_we_i <= 1'b0;
  endtask

  // Readback lags the address by one cycle
  task automatic csr_read(input logic [2:0] off, output logic [31:0] data);
    @(posedge mpu_clk);
    csr_a_i <= csr_addr(off);
    @(posedge mpu_clk);
    @(negedge mpu_clk);
    data = csr_do_o;
  endtask

  task automatic read_result(output logic [63:0] data);
    logic [31:0] lo;
    logic [31:0] hi;
    csr_read(`CHECKER_REG_DATA_LO, lo);
    csr_read(`CHECKER_REG_DATA_HI, hi);
    data = {hi, lo};
  endtask

  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    @(posedge mpu_clk);
    wb_i.cyc <= 1'b1;
    wb_i.stb <= 1'b1;
    wb_i.we  <= we;
    wb_i.adr <= adr;
    wb_i.dat <= dat;
    @(negedge mpu_clk);
    check_eq("wb_ack_o", 64'(wb_ack_o), 64'd0);
    @(negedge mpu_clk);
    check_eq("wb_ack_o", 64'(wb_ack_o), 64'd1);
    rdata = wb_dat_o;
    @(posedge mpu_clk);
    wb_i.cyc <= 1'b0;
    wb_i.stb <= 1'b0;
    wb_i.we  <= 1'b0;
  endtask

  task automatic prog_write(input logic [7:0] idx, input logic [47:0] word);
    logic [31:0] rd;
    wb_access(1'b1, {21'd0, idx, 3'b000}, word[31:0], rd);
    wb_access(1'b1, {21'd0, idx, 3'b100}, {16'd0, word[47:32]}, rd);
  endtask

  // Random ADD and XOR ops, an optional IRQ, then the tail op
  task automatic build_program(input logic [7:0] base, input int n,
                               input checker_pkg::op_e tail, input bit with_irq,
                               output logic [63:0] acc);
    logic [63:0] r;
    logic [47:0] word;
    int          k;
    acc = '0;
    for (k = 0; k < n; k++) begin
      r = next_rand();
      if (r[63]) begin
        word = {checker_pkg::OP_XOR, r[39:0]};
        acc  = acc ^ {24'd0, r[39:0]};
      end else begin
        word = {checker_pkg::OP_ADD, r[39:0]};
        acc  = acc + {24'd0, r[39:0]};
      end
      prog_write(base + 8'(k), word);
    end
    if (with_irq) begin
      prog_write(base + 8'(k), {checker_pkg::OP_IRQ, 40'd0});
      k++;
    end
    prog_write(base + 8'(k), {tail, 40'd0});
  endtask

  task automatic start_run(input checker_pkg::mode_e mode, input logic [63:0] addr);
    csr_write(`CHECKER_REG_ADDR_LO, addr[31:0]);
    csr_write(`CHECKER_REG_ADDR_HI, addr[63:32]);
    csr_write(`CHECKER_REG_CTRL, {29'd0, mode, 1'b1});
  endtask

  // Poll STATUS until busy drops and note irq seen while still busy
  task automatic wait_idle(output bit irq_early);
    logic [31:0] status;
    logic        irq_prev;
    int          n;
    irq_early = 1'b0;
    n = 0;
    @(posedge mpu_clk);
    csr_a_i <= csr_addr(`CHECKER_REG_STATUS);
    @(negedge mpu_clk);
    irq_prev = irq_o;
    do begin
      @(posedge mpu_clk);
      @(negedge mpu_clk);
      status = csr_do_o;
      // Busy in STATUS is one cycle old and pairs with the previous irq_o
      if (irq_prev && status[0]) begin
        irq_early = 1'b1;
      end
      irq_prev = irq_o;
      n++;
    end while (status[0] && n < RUN_LIMIT);
    if (status[0]) begin
      err_other++;
      $display("Run still busy after %0d cycles", RUN_LIMIT);
    end
  endtask

  task automatic dummy_run(input checker_pkg::mode_e mode);
    logic [63:0] data;
    @(posedge mpu_clk);
    csr_a_i  <= csr_addr(`CHECKER_REG_CTRL);
    csr_we_i <= 1'b1;
    csr_di_i <= {29'd0, mode, 1'b1};
    @(posedge mpu_clk);
    csr_a_i  <= csr_addr(`CHECKER_REG_STATUS);
    csr_we_i <= 1'b0;
    // Busy for exactly two cycles after the write edge
    repeat (2) begin
      @(posedge mpu_clk);
      @(negedge mpu_clk);
      check_eq("STATUS.busy", 64'(csr_do_o[0]), 64'd1);
    end
    @(posedge mpu_clk);
    @(negedge mpu_clk);
    check_eq("STATUS.busy", 64'(csr_do_o[0]), 64'd0);
    read_result(data);
    check_eq("DATA", data, 64'd0);
  endtask

  // Host memory answers after 1 to 20 cycles unless told to hold a word
  initial begin
    logic [63:0] addr;
    int          delay;
    forever begin
      @(negedge mpu_clk);
      if (!mpu_rst && hm_req_o.valid) begin
        addr = hm_req_o.addr;
        check_eq("hm_req_o.addr", addr, hm_base + 64'(hm_idx) * 64'd8);
        delay = int'(next_rand() % 64'd20) + 1;
        if (hm_idx != hm_hold) begin
          repeat (delay) @(posedge mpu_clk);
          hm_rsp_i.data  <= xorshift64(addr);
          hm_rsp_i.valid <= 1'b1;
          @(posedge mpu_clk);
          hm_rsp_i.valid <= 1'b0;
        end
        hm_idx++;
      end
    end
  end

  ack_one_cycle: assert property (@(posedge mpu_clk) disable iff (mpu_rst)
    wb_ack_o |=> !wb_ack_o)
    else begin
      err_proto++;
      $display("wb_ack_o stayed high for more than one cycle");
    end

  ack_after_strobe: assert property (@(posedge mpu_clk) disable iff (mpu_rst)
    (wb_i.cyc && wb_i.stb && !wb_ack_o) |=> wb_ack_o)
    else begin
      err_proto++;
      $display("No wb_ack_o in the cycle after a Wishbone strobe");
    end

  req_one_cycle: assert property (@(posedge mpu_clk) disable iff (mpu_rst)
    hm_req_o.valid |=> !hm_req_o.valid)
    else begin
      err_proto++;
      $display("Host request valid held for more than one cycle");
    end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge mpu_clk);
      cycles++;
    end
    $display("Timeout: the run was stopped after %0d cycles", CYCLE_LIMIT);
    $display("Errors: %0d value, %0d protocol, %0d other", err_value, err_proto, err_other);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [63:0] r;
    logic [63:0] acc;
    logic [63:0] data;
    logic [63:0] base;
    logic [63:0] sum;
    bit          irq_early;
    int          i;
    err_value = 0;
    err_proto = 0;
    err_other = 0;
    rng_state = 64'd44;
    hm_base   = '0;
    hm_idx    = 0;
    hm_hold   = -1;
    csr_a_i   = '0;
    csr_we_i  = 1'b0;
    csr_di_i  = '0;
    wb_i      = '0;
    hm_rsp_i  = '0;
    mpu_rst   = 1'b1;
    repeat (2) @(posedge mpu_clk);
    mpu_rst <= 1'b0;

    @(negedge mpu_clk);
    check_eq("irq_o", 64'(irq_o), 64'd0);
    check_eq("wb_ack_o", 64'(wb_ack_o), 64'd0);
    check_eq("hm_req_o.valid", 64'(hm_req_o.valid), 64'd0);
    csr_read(`CHECKER_REG_STATUS, rd);
    check_eq("STATUS", 64'(rd), 64'd0);

    // Odd half of word 0x80 keeps only 16 bits
    r = next_rand();
    wb_access(1'b1, 32'h400, r[31:0], rd);
    wb_access(1'b1, 32'h404, r[63:32], rd);
    wb_access(1'b0, 32'h400, 32'd0, rd);
    check_eq("wb_dat_o", 64'(rd), 64'(r[31:0]));
    wb_access(1'b0, 32'h404, 32'd0, rd);
    check_eq("wb_dat_o", 64'(rd), 64'(r[47:32]));

    build_program(8'h10, 20, checker_pkg::OP_END, 1'b0, acc);
    start_run(checker_pkg::MODE_SINGLE, 64'h10);
    wait_idle(irq_early);
    read_result(data);
    check_eq("DATA", data, acc);
    csr_read(`CHECKER_REG_STATUS, rd);
    check_eq("STATUS.error", 64'(rd[1]), 64'd0);
    check_eq("irq_o", 64'(irq_o), 64'd1);
    csr_write(`CHECKER_REG_STATUS, 32'd0);
    @(posedge mpu_clk);
    @(negedge mpu_clk);
    check_eq("irq_o", 64'(irq_o), 64'd0);

    build_program(8'h30, 20, checker_pkg::OP_END, 1'b1, acc);
    start_run(checker_pkg::MODE_SINGLE, 64'h30);
    wait_idle(irq_early);
    check_eq("irq_o before busy falls", 64'(irq_early), 64'd1);
    read_result(data);
    check_eq("DATA", data, acc);

    build_program(8'h50, 20, checker_pkg::OP_FAIL, 1'b0, acc);
    start_run(checker_pkg::MODE_SINGLE, 64'h50);
    wait_idle(irq_early);
    csr_read(`CHECKER_REG_STATUS, rd);
    check_eq("STATUS.error", 64'(rd[1]), 64'd1);
    read_result(data);
    check_eq("DATA", data, acc);

    // Full page read
    base    = next_rand() & ~64'h7;
    hm_base = base;
    hm_idx  = 0;
    hm_hold = -1;
    sum     = '0;
    for (i = 0; i < `CHECKER_PAGE_WORDS; i++) begin
      sum = sum + xorshift64(base + 64'(i) * 64'd8);
    end
    start_run(checker_pkg::MODE_READ, base);
    wait_idle(irq_early);
    read_result(data);
    check_eq("DATA", data, sum);
    check_eq("hm_req_o.valid count", 64'(hm_idx), 64'd8);
    csr_read(`CHECKER_REG_STATUS, rd);
    check_eq("STATUS.error", 64'(rd[1]), 64'd0);

    // Fourth response withheld
    base    = next_rand() & ~64'h7;
    hm_base = base;
    hm_idx  = 0;
    hm_hold = 3;
    sum     = '0;
    for (i = 0; i < 3; i++) begin
      sum = sum + xorshift64(base + 64'(i) * 64'd8);
    end
    start_run(checker_pkg::MODE_READ, base);
    wait_idle(irq_early);
    read_result(data);
    check_eq("DATA", data, sum);
    check_eq("hm_req_o.valid count", 64'(hm_idx), 64'd4);
    csr_read(`CHECKER_REG_STATUS, rd);
    check_eq("STATUS.error", 64'(rd[1]), 64'd1);

    dummy_run(checker_pkg::MODE_DUMMY);
    dummy_run(checker_pkg::MODE_AUTO);

    // Second start and program write during a run
    build_program(8'h10, 20, checker_pkg::OP_END, 1'b0, acc);
    start_run(checker_pkg::MODE_SINGLE, 64'h10);
    csr_write(`CHECKER_REG_CTRL, {29'd0, checker_pkg::MODE_DUMMY, 1'b1});
    wb_access(1'b1, 32'h400, ~r[31:0], rd);
    wait_idle(irq_early);
    read_result(data);
    check_eq("DATA", data, acc);
    wb_access(1'b0, 32'h400, 32'd0, rd);
    check_eq("wb_dat_o", 64'(rd), 64'(r[31:0]));

    repeat (2) @(posedge mpu_clk);
    $display("Errors: %0d value, %0d protocol, %0d other", err_value, err_proto, err_other);
    if (err_value + err_proto + err_other == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
checker_pkg.sv
checker_ctlif.sv
checker_prog_mem.sv
checker_single.sv
checker_read.sv
checker_result.sv
checker_top.sv
tb_checker.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
verilator --binary --assert -Wno-fatal --top-module tb_checker -f tb.f -o tb_checker_sim \
  && ./obj_dir/tb_checker_sim | tee sim.log \
  && grep -q "Verification passed" sim.log \
  || exit 1
